/* sim.f */
src/fpu_pkg.sv
src/fpu_tag_store.sv
src/fpu_misc_pipe.sv
src/fpu_rsp_buffer.sv
src/fpu_fflags_csr.sv
src/fpu_unit.sv
bench/fpu_unit_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --assert --timing -Wno-fatal
TOP       ?= fpu_unit_tb
FILELIST  ?= sim.f
OBJDIR    ?= obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf $(OBJDIR)

/* bench/fpu_unit_tb.sv */
// directed testbench that checks the fpu unit against a lane reference model
`timescale 1ns/100ps

module fpu_unit_tb import fpu_pkg::*; ();

    typedef logic [num_lanes-1:0][xlen-1:0] lanes_t;

    localparam int wait_limit = 200;
    localparam int long_limit = 4000;

    logic                 clk;
    logic                 reset;
    logic                 req_valid;
    logic                 req_ready;
    logic [wid_bits-1:0]  req_wid;
    logic [nr_bits-1:0]   req_rd;
    logic [num_lanes-1:0] req_tmask;
    logic [op_bits-1:0]   req_op;
    lanes_t               req_rs1;
    lanes_t               req_rs2;
    logic                 commit_valid;
    logic                 commit_ready;
    logic [wid_bits-1:0]  commit_wid;
    logic [nr_bits-1:0]   commit_rd;
    logic [num_lanes-1:0] commit_tmask;
    lanes_t               commit_data;
    logic [wid_bits-1:0]  csr_read_wid;
    fflags_t              csr_read_fflags;
    logic                 csr_clear_en;
    logic [wid_bits-1:0]  csr_clear_wid;

    integer               seed = 32'h6eb850ba;
    int                   errors = 0;
    int                   checks = 0;
    int                   received = 0;
    logic [num_warps-1:0] flag_nv;

    // results still owed by the DUT in request order
    logic [wid_bits-1:0]  exp_wid [$];
    logic [nr_bits-1:0]   exp_rd [$];
    logic [num_lanes-1:0] exp_tmask [$];
    lanes_t               exp_data [$];

    fpu_unit i_fpu_unit (
        .clk             (clk),
        .reset           (reset),
        .req_valid       (req_valid),
        .req_ready       (req_ready),
        .req_wid         (req_wid),
        .req_rd          (req_rd),
        .req_tmask       (req_tmask),
        .req_op          (req_op),
        .req_rs1         (req_rs1),
        .req_rs2         (req_rs2),
        .commit_valid    (commit_valid),
        .commit_ready    (commit_ready),
        .commit_wid      (commit_wid),
        .commit_rd       (commit_rd),
        .commit_tmask    (commit_tmask),
        .commit_data     (commit_data),
        .csr_read_wid    (csr_read_wid),
        .csr_read_fflags (csr_read_fflags),
        .csr_clear_en    (csr_clear_en),
        .csr_clear_wid   (csr_clear_wid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check(input logic ok, input string what);
        checks++;
        assert (ok) else begin
            $display("FAILED %0t ns: %s", $time, what);
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int start);
        $display("test %-12s %s", name,
            errors == start ? "ok" : $sformatf("%0d errors", errors - start));
    endtask

    function automatic logic [9:0] class_mask(input logic [xlen-1:0] v);
        logic [9:0] mask;
        mask = '0;
        if (v[30:23] == 8'hff) begin
            if (v[22:0] == 23'd0) begin
                mask[v[31] ? cls_neg_inf : cls_pos_inf] = 1'b1;
            end else begin
                mask[v[22] ? cls_qnan : cls_snan] = 1'b1;
            end
        end else if (v[30:23] == 8'h00) begin
            if (v[22:0] == 23'd0) begin
                mask[v[31] ? cls_neg_zero : cls_pos_zero] = 1'b1;
            end else begin
                mask[v[31] ? cls_neg_sub : cls_pos_sub] = 1'b1;
            end
        end else begin
            mask[v[31] ? cls_neg_norm : cls_pos_norm] = 1'b1;
        end
        return mask;
    endfunction

    // expected {nv, result} of one active lane
    function automatic logic [xlen:0] model_lane(input logic [op_bits-1:0] op,
                                                 input logic [xlen-1:0] a,
                                                 input logic [xlen-1:0] b);
        logic [9:0]      ca;
        logic [9:0]      cb;
        logic            na;
        logic            nb;
        logic            snan;
        logic [xlen-1:0] pick;
        longint          ka;
        longint          kb;
        longint          ea;
        longint          eb;
        ca   = class_mask(a);
        cb   = class_mask(b);
        na   = ca[cls_qnan] | ca[cls_snan];
        nb   = cb[cls_qnan] | cb[cls_snan];
        snan = ca[cls_snan] | cb[cls_snan];
        // min and max put -0 below +0 while compares see them as equal
        ka = a[31] ? -longint'(a[30:0]) - 1 : longint'(a[30:0]);
        kb = b[31] ? -longint'(b[30:0]) - 1 : longint'(b[30:0]);
        ea = a[31] ? -longint'(a[30:0]) : longint'(a[30:0]);
        eb = b[31] ? -longint'(b[30:0]) : longint'(b[30:0]);
        pick = (na && nb) ? canonical_nan
             : na ? b
             : nb ? a
             : ((ka < kb) == (op == op_min)) ? a : b;
        case (op)
            op_sgnj:        return {1'b0, b[31], a[30:0]};
            op_sgnjn:       return {1'b0, ~b[31], a[30:0]};
            op_sgnjx:       return {1'b0, a[31] ^ b[31], a[30:0]};
            op_min, op_max: return {snan, pick};
            op_feq:         return {snan, 31'd0, !na && !nb && ea == eb};
            op_flt:         return {na | nb, 31'd0, !na && !nb && ea < eb};
            op_fle:         return {na | nb, 31'd0, !na && !nb && ea <= eb};
            op_fclass:      return {1'b0, 22'd0, ca};
            default:        return '0;
        endcase
    endfunction

    task automatic send_req(input logic [wid_bits-1:0] wid, input logic [nr_bits-1:0] rd,
                            input logic [num_lanes-1:0] tmask, input logic [op_bits-1:0] op,
                            input lanes_t rs1, input lanes_t rs2);
        lanes_t        expect_data;
        logic [xlen:0] lane;
        logic          any_nv;
        int            n;
        any_nv = 1'b0;
        for (int i = 0; i < num_lanes; i++) begin
            lane           = model_lane(op, rs1[i], rs2[i]);
            expect_data[i] = tmask[i] ? lane[xlen-1:0] : '0;
            any_nv         = any_nv | (tmask[i] & lane[xlen]);
        end
        exp_wid.push_back(wid);
        exp_rd.push_back(rd);
        exp_tmask.push_back(tmask);
        exp_data.push_back(expect_data);
        flag_nv[wid] = flag_nv[wid] | any_nv;
        @(posedge clk);
        req_valid <= 1'b1;
        req_wid   <= wid;
        req_rd    <= rd;
        req_tmask <= tmask;
        req_op    <= op;
        req_rs1   <= rs1;
        req_rs2   <= rs2;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!req_ready && n < wait_limit);
        if (!req_ready) begin
            $display("timeout at %0t ns: the DUT never accepted a request", $time);
            errors++;
        end
        @(posedge clk);
        req_valid <= 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_data.size() > 0 && n < long_limit) begin
            @(negedge clk);
            n++;
        end
        if (exp_data.size() > 0) begin
            $display("timeout: %0d results never reached the commit port", exp_data.size());
            errors++;
            exp_wid.delete();
            exp_rd.delete();
            exp_tmask.delete();
            exp_data.delete();
        end
    endtask

    // each result is checked as it leaves the commit port
    always @(negedge clk) begin
        if (!reset && commit_valid && commit_ready) begin
            if (exp_data.size() == 0) begin
                $display("a result came out at %0t ns with no request outstanding", $time);
                errors++;
            end else begin
                check(commit_wid == exp_wid[0] && commit_rd == exp_rd[0]
                      && commit_tmask == exp_tmask[0] && commit_data == exp_data[0],
                      $sformatf("result %0d got %0d %0d %b %h, expected %0d %0d %b %h",
                                received, commit_wid, commit_rd, commit_tmask, commit_data,
                                exp_wid[0], exp_rd[0], exp_tmask[0], exp_data[0]));
                void'(exp_wid.pop_front());
                void'(exp_rd.pop_front());
                void'(exp_tmask.pop_front());
                void'(exp_data.pop_front());
                received++;
            end
        end
    end

    task automatic clear_flags(input int w);
        @(posedge clk);
        csr_clear_en  <= 1'b1;
        csr_clear_wid <= wid_bits'(w);
        @(posedge clk);
        csr_clear_en <= 1'b0;
        flag_nv[w] = 1'b0;
    endtask

    task automatic compare_flags(input int w);
        @(posedge clk);
        csr_read_wid <= wid_bits'(w);
        @(negedge clk);
        check(csr_read_fflags == {flag_nv[w], 4'b0000},
              $sformatf("warp %0d fflags %b, expected nv %b", w, csr_read_fflags, flag_nv[w]));
    endtask

    task automatic sign_inject_random();
        lanes_t a;
        lanes_t b;
        int     start;
        start = errors;
        for (int op = 0; op < 3; op++) begin
            for (int k = 0; k < 3; k++) begin
                a[0] = $random(seed);
                a[1] = $random(seed);
                b[0] = $random(seed);
                b[1] = $random(seed);
                send_req(wid_bits'($random(seed)), nr_bits'($random(seed)),
                         num_lanes'(k + 1), op_bits'(op_sgnj + op), a, b);
            end
        end
        wait_drain();
        end_test("sign_inject", start);
    endtask

    task automatic min_max_compare();
        logic [xlen-1:0] vals [9] = '{32'h00000000, 32'h80000000, 32'h7f800000,
                                      32'hff800000, 32'h7fc00001, 32'h7f800001,
                                      32'h3f800000, 32'hc0200000, 32'h00000123};
        lanes_t a;
        lanes_t b;
        int     start;
        start = errors;
        for (int op = op_min; op <= op_fle; op++) begin
            for (int i = 0; i < 9; i++) begin
                for (int j = 0; j < 9; j++) begin
                    a[0] = vals[i];
                    b[0] = vals[j];
                    a[1] = vals[j];
                    b[1] = vals[i];
                    send_req(wid_bits'(i), nr_bits'(j), 2'b11, op_bits'(op), a, b);
                end
            end
        end
        wait_drain();
        end_test("min_max_cmp", start);
    endtask

    task automatic classify_all();
        // one value per class in fclass bit order
        logic [xlen-1:0] vals [10] = '{32'hff800000, 32'hbf800000, 32'h80000001,
                                       32'h80000000, 32'h00000000, 32'h00000001,
                                       32'h3f800000, 32'h7f800000, 32'h7f800001,
                                       32'h7fc00000};
        lanes_t a;
        lanes_t b;
        int     start;
        start = errors;
        for (int k = 0; k < 10; k++) begin
            a[0] = vals[k];
            a[1] = vals[9 - k];
            b[0] = $random(seed);
            b[1] = $random(seed);
            send_req(2'd1, nr_bits'(k), 2'b11, op_fclass, a, b);
        end
        wait_drain();
        end_test("classify", start);
    endtask

    task automatic flag_accrue_clear();
        lanes_t a;
        lanes_t b;
        int     start;
        start = errors;
        for (int w = 0; w < num_warps; w++) begin
            clear_flags(w);
        end
        a = {32'h00000000, 32'h7f800001};
        b = {32'h00000000, 32'h3f800000};
        send_req(2'd1, 5'd1, 2'b11, op_min, a, b);
        // the nan sits in lane 1
        a = {32'h7fc00000, 32'h3f800000};
        b = {32'h00000000, 32'h40000000};
        send_req(2'd2, 5'd2, 2'b01, op_flt, a, b);
        send_req(2'd3, 5'd3, 2'b10, op_flt, a, b);
        send_req(2'd0, 5'd4, 2'b11, op_sgnjx, a, b);
        wait_drain();
        for (int w = 0; w < num_warps; w++) begin
            compare_flags(w);
        end
        clear_flags(1);
        for (int w = 0; w < num_warps; w++) begin
            compare_flags(w);
        end
        end_test("flags", start);
    endtask

    task automatic backpressure_order();
        lanes_t a;
        lanes_t b;
        logic   stalled;
        int     target;
        int     n;
        int     start;
        start   = errors;
        target  = received + 8;
        stalled = 1'b0;
        @(posedge clk);
        commit_ready <= 1'b0;
        fork
            begin
                for (int k = 0; k < 8; k++) begin
                    a[0] = $random(seed);
                    a[1] = $random(seed);
                    b[0] = $random(seed);
                    b[1] = $random(seed);
                    send_req(wid_bits'(k), nr_bits'(k + 8), 2'b11,
                             op_bits'($unsigned($random(seed)) % 9), a, b);
                end
            end
            begin
                n = 0;
                while (!stalled && n < wait_limit) begin
                    @(negedge clk);
                    n++;
                    stalled = req_valid && !req_ready;
                end
                n = 0;
                while (received < target && n < long_limit) begin
                    @(posedge clk);
                    commit_ready <= 1'($random(seed));
                    n++;
                end
            end
        join
        @(posedge clk);
        commit_ready <= 1'b1;
        wait_drain();
        check(stalled, "req_ready stayed high while the commit port was blocked");
        end_test("backpressure", start);
    endtask

    task automatic isolated_latency();
        lanes_t a;
        lanes_t b;
        int     n;
        int     start;
        start = errors;
        a = {32'h3f800000, 32'hc0200000};
        b = {32'h40000000, 32'h80000000};
        send_req(2'd2, 5'd7, 2'b11, op_max, a, b);
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!commit_valid && n < wait_limit);
        check(commit_valid && n == 3, $sformatf("commit_valid after %0d cycles, expected 3", n));
        wait_drain();
        end_test("latency", start);
    endtask

    initial begin
        reset         = 1'b1;
        req_valid     = 1'b0;
        req_wid       = '0;
        req_rd        = '0;
        req_tmask     = '0;
        req_op        = '0;
        req_rs1       = '0;
        req_rs2       = '0;
        commit_ready  = 1'b1;
        csr_read_wid  = '0;
        csr_clear_en  = 1'b0;
        csr_clear_wid = '0;
        flag_nv       = '0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check(req_ready && !commit_valid && csr_read_fflags == '0,
              $sformatf("after reset req_ready %b commit_valid %b fflags %b",
                        req_ready, commit_valid, csr_read_fflags));
        sign_inject_random();
        min_max_compare();
        classify_all();
        flag_accrue_clear();
        backpressure_order();
        isolated_latency();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* src/fpu_unit.sv */
// fpu unit: misc fp execute block with tag store, lane pipe, flag csr and commit buffer
`timescale 1ns/100ps

module fpu_unit import fpu_pkg::*; (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           req_valid,
    output logic                           req_ready,
    input  logic [wid_bits-1:0]            req_wid,
    input  logic [nr_bits-1:0]             req_rd,
    input  logic [num_lanes-1:0]           req_tmask,
    input  logic [op_bits-1:0]             req_op,
    input  logic [num_lanes-1:0][xlen-1:0] req_rs1,
    input  logic [num_lanes-1:0][xlen-1:0] req_rs2,
    output logic                           commit_valid,
    input  logic                           commit_ready,
    output logic [wid_bits-1:0]            commit_wid,
    output logic [nr_bits-1:0]             commit_rd,
    output logic [num_lanes-1:0]           commit_tmask,
    output logic [num_lanes-1:0][xlen-1:0] commit_data,
    input  logic [wid_bits-1:0]            csr_read_wid,
    output fflags_t                        csr_read_fflags,
    input  logic                           csr_clear_en,
    input  logic [wid_bits-1:0]            csr_clear_wid
);

    logic                           tags_full;
    logic                           pipe_ready_in;
    logic                           req_fire;
    logic [tag_bits-1:0]            req_tag;
    logic                           rsp_valid;
    logic                           rsp_ready;
    logic                           rsp_fire;
    logic [tag_bits-1:0]            rsp_tag;
    logic [num_lanes-1:0][xlen-1:0] rsp_result;
    fflags_t                        rsp_fflags;
    logic [wid_bits-1:0]            rsp_wid;
    logic [nr_bits-1:0]             rsp_rd;
    logic [num_lanes-1:0]           rsp_tmask;

    assign req_ready = pipe_ready_in && !tags_full;
    assign req_fire  = req_valid && req_ready;
    assign rsp_fire  = rsp_valid && rsp_ready;

    fpu_tag_store i_tag_store (
        .clk         (clk),
        .reset       (reset),
        .acquire_en  (req_fire),
        .write_wid   (req_wid),
        .write_rd    (req_rd),
        .write_tmask (req_tmask),
        .write_tag   (req_tag),
        .release_en  (rsp_fire),
        .read_tag    (rsp_tag),
        .read_wid    (rsp_wid),
        .read_rd     (rsp_rd),
        .read_tmask  (rsp_tmask),
        .full        (tags_full)
    );

    fpu_misc_pipe i_misc_pipe (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (req_valid && !tags_full),
        .ready_in  (pipe_ready_in),
        .op        (req_op),
        .lane_mask (req_tmask),
        .dataa     (req_rs1),
        .datab     (req_rs2),
        .tag_in    (req_tag),
        .valid_out (rsp_valid),
        .ready_out (rsp_ready),
        .result    (rsp_result),
        .fflags    (rsp_fflags),
        .tag_out   (rsp_tag)
    );

    // flags accrue on the warp whose result is leaving the pipe
    fpu_fflags_csr i_fflags_csr (
        .clk          (clk),
        .reset        (reset),
        .write_enable (rsp_fire),
        .write_wid    (rsp_wid),
        .write_fflags (rsp_fflags),
        .clear_en     (csr_clear_en),
        .clear_wid    (csr_clear_wid),
        .read_wid     (csr_read_wid),
        .read_fflags  (csr_read_fflags)
    );

    fpu_rsp_buffer i_rsp_buffer (
        .clk        (clk),
        .reset      (reset),
        .valid_in   (rsp_valid),
        .ready_in   (rsp_ready),
        .wid_in     (rsp_wid),
        .rd_in      (rsp_rd),
        .tmask_in   (rsp_tmask),
        .result_in  (rsp_result),
        .valid_out  (commit_valid),
        .ready_out  (commit_ready),
        .wid_out    (commit_wid),
        .rd_out     (commit_rd),
        .tmask_out  (commit_tmask),
        .result_out (commit_data)
    );

endmodule

/* src/fpu_fflags_csr.sv */
// fpu fflags csr: accrued exception flags per warp with read port and clear
`timescale 1ns/100ps

module fpu_fflags_csr import fpu_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                write_enable,
    input  logic [wid_bits-1:0] write_wid,
    input  fflags_t             write_fflags,
    input  logic                clear_en,
    input  logic [wid_bits-1:0] clear_wid,
    input  logic [wid_bits-1:0] read_wid,
    output fflags_t             read_fflags
);

    fflags_t fflags_q [num_warps];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < num_warps; w++) begin
                fflags_q[w] <= '0;
            end
        end else begin
            for (int w = 0; w < num_warps; w++) begin
                // clear wins over a same-cycle accrue
                if (clear_en && clear_wid == wid_bits'(w)) begin
                    fflags_q[w] <= '0;
                end else if (write_enable && write_wid == wid_bits'(w)) begin
                    fflags_q[w] <= fflags_q[w] | write_fflags;
                end
            end
        end
    end

    assign read_fflags = fflags_q[read_wid];

endmodule

/* src/fpu_rsp_buffer.sv */
// two-entry skid buffer holding fpu results in front of the commit port
`timescale 1ns/100ps

module fpu_rsp_buffer import fpu_pkg::*; (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           valid_in,
    output logic                           ready_in,
    input  logic [wid_bits-1:0]            wid_in,
    input  logic [nr_bits-1:0]             rd_in,
    input  logic [num_lanes-1:0]           tmask_in,
    input  logic [num_lanes-1:0][xlen-1:0] result_in,
    output logic                           valid_out,
    input  logic                           ready_out,
    output logic [wid_bits-1:0]            wid_out,
    output logic [nr_bits-1:0]             rd_out,
    output logic [num_lanes-1:0]           tmask_out,
    output logic [num_lanes-1:0][xlen-1:0] result_out
);

    logic                           skid_valid;
    logic [wid_bits-1:0]            skid_wid;
    logic [nr_bits-1:0]             skid_rd;
    logic [num_lanes-1:0]           skid_tmask;
    logic [num_lanes-1:0][xlen-1:0] skid_result;
    logic                           out_move;

    assign ready_in = !skid_valid;
    assign out_move = !valid_out || ready_out;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_out  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (out_move) begin
            valid_out  <= skid_valid || valid_in;
            skid_valid <= 1'b0;
        end else if (valid_in && ready_in) begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (out_move) begin
            // drain the skid entry first to keep order
            wid_out    <= skid_valid ? skid_wid : wid_in;
            rd_out     <= skid_valid ? skid_rd : rd_in;
            tmask_out  <= skid_valid ? skid_tmask : tmask_in;
            result_out <= skid_valid ? skid_result : result_in;
        end else if (valid_in && ready_in) begin
            skid_wid    <= wid_in;
            skid_rd     <= rd_in;
            skid_tmask  <= tmask_in;
            skid_result <= result_in;
        end
    end

    // an item refused while the skid entry is taken must wait unchanged at the input
    assert property (@(posedge clk) disable iff (reset)
        valid_in && !ready_in |=> valid_in && $stable(wid_in) && $stable(rd_in)
            && $stable(tmask_in) && $stable(result_in));

endmodule

/* src/fpu_misc_pipe.sv */
// fpu misc pipe: two-stage lane pipe for sign injection, min/max, compares and classify
`timescale 1ns/100ps

module fpu_misc_pipe import fpu_pkg::*; (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            valid_in,
    output logic                            ready_in,
    input  logic [op_bits-1:0]              op,
    input  logic [num_lanes-1:0]            lane_mask,
    input  logic [num_lanes-1:0][xlen-1:0]  dataa,
    input  logic [num_lanes-1:0][xlen-1:0]  datab,
    input  logic [tag_bits-1:0]             tag_in,
    output logic                            valid_out,
    input  logic                            ready_out,
    output logic [num_lanes-1:0][xlen-1:0]  result,
    output fflags_t                         fflags,
    output logic [tag_bits-1:0]             tag_out
);

    logic                           s1_valid;
    logic                           s1_ready;
    logic                           s2_ready;
    logic [op_bits-1:0]             s1_op;
    logic [num_lanes-1:0]           s1_mask;
    logic [num_lanes-1:0][xlen-1:0] s1_a;
    logic [num_lanes-1:0][xlen-1:0] s1_b;
    logic [tag_bits-1:0]            s1_tag;
    logic [num_lanes-1:0][xlen-1:0] res_d;
    logic [num_lanes-1:0]           nv_d;
    fflags_t                        flags_d;

    function automatic logic [9:0] fclass(fp32_t v);
        logic exp_max;
        logic exp_zero;
        logic frac_zero;
        exp_max   = &v.f.exp;
        exp_zero  = ~|v.f.exp;
        frac_zero = ~|v.f.frac;
        fclass    = '0;
        if (exp_max && frac_zero) begin
            fclass[v.f.sign ? cls_neg_inf : cls_pos_inf] = 1'b1;
        end else if (exp_max) begin
            // quiet bit is the top fraction bit
            fclass[v.f.frac[22] ? cls_qnan : cls_snan] = 1'b1;
        end else if (exp_zero && frac_zero) begin
            fclass[v.f.sign ? cls_neg_zero : cls_pos_zero] = 1'b1;
        end else if (exp_zero) begin
            fclass[v.f.sign ? cls_neg_sub : cls_pos_sub] = 1'b1;
        end else begin
            fclass[v.f.sign ? cls_neg_norm : cls_pos_norm] = 1'b1;
        end
    endfunction

    // total order on non-nan values, -0 below +0
    function automatic logic less_than(fp32_t a, fp32_t b);
        if (a.f.sign != b.f.sign) begin
            return a.f.sign;
        end
        return a.f.sign ? (a.bits > b.bits) : (a.bits < b.bits);
    endfunction

    assign s2_ready = !valid_out || ready_out;
    assign s1_ready = !s1_valid || s2_ready;
    assign ready_in = s1_ready;

    always_comb begin
        fp32_t      a;
        fp32_t      b;
        logic [9:0] cls_a;
        logic [9:0] cls_b;
        logic       nan_a;
        logic       nan_b;
        logic       nan_any;
        logic       snan_any;
        logic       zeros;
        logic       lt;
        logic       eq;
        res_d = '0;
        nv_d  = '0;
        for (int i = 0; i < num_lanes; i++) begin
            a        = s1_a[i];
            b        = s1_b[i];
            cls_a    = fclass(a);
            cls_b    = fclass(b);
            nan_a    = cls_a[cls_snan] | cls_a[cls_qnan];
            nan_b    = cls_b[cls_snan] | cls_b[cls_qnan];
            nan_any  = nan_a | nan_b;
            snan_any = cls_a[cls_snan] | cls_b[cls_snan];
            zeros    = (cls_a[cls_neg_zero] | cls_a[cls_pos_zero])
                     & (cls_b[cls_neg_zero] | cls_b[cls_pos_zero]);
            // compares see -0 and +0 as equal
            lt = less_than(a, b) && !zeros;
            eq = (a.bits == b.bits) || zeros;
            case (s1_op)
                op_sgnj:  res_d[i] = {b.f.sign, a.bits[xlen-2:0]};
                op_sgnjn: res_d[i] = {~b.f.sign, a.bits[xlen-2:0]};
                op_sgnjx: res_d[i] = {a.f.sign ^ b.f.sign, a.bits[xlen-2:0]};
                op_min, op_max: begin
                    if (nan_a && nan_b) begin
                        res_d[i] = canonical_nan;
                    end else if (nan_a) begin
                        res_d[i] = b.bits;
                    end else if (nan_b) begin
                        res_d[i] = a.bits;
                    end else if (less_than(a, b) == (s1_op == op_min)) begin
                        res_d[i] = a.bits;
                    end else begin
                        res_d[i] = b.bits;
                    end
                    nv_d[i] = snan_any;
                end
                op_feq: begin
                    res_d[i] = xlen'(!nan_any && eq);
                    nv_d[i]  = snan_any;
                end
                op_flt: begin
                    res_d[i] = xlen'(!nan_any && lt);
                    nv_d[i]  = nan_any;
                end
                op_fle: begin
                    res_d[i] = xlen'(!nan_any && (lt || eq));
                    nv_d[i]  = nan_any;
                end
                op_fclass: res_d[i] = xlen'(cls_a);
                default:   res_d[i] = '0;
            endcase
            if (!s1_mask[i]) begin
                res_d[i] = '0;
                nv_d[i]  = 1'b0;
            end
        end
        flags_d    = '0;
        flags_d.nv = |nv_d;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid  <= 1'b0;
            valid_out <= 1'b0;
        end else begin
            if (s1_ready) begin
                s1_valid <= valid_in;
            end
            if (s2_ready) begin
                valid_out <= s1_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s1_ready && valid_in) begin
            s1_op   <= op;
            s1_mask <= lane_mask;
            s1_a    <= dataa;
            s1_b    <= datab;
            s1_tag  <= tag_in;
        end
        if (s2_ready && s1_valid) begin
            result  <= res_d;
            fflags  <= flags_d;
            tag_out <= s1_tag;
        end
    end

endmodule

/* src/fpu_tag_store.sv */
// fpu tag store: index buffer holding request metadata while the request is in flight
`timescale 1ns/100ps

module fpu_tag_store import fpu_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 acquire_en,
    input  logic [wid_bits-1:0]  write_wid,
    input  logic [nr_bits-1:0]   write_rd,
    input  logic [num_lanes-1:0] write_tmask,
    output logic [tag_bits-1:0]  write_tag,
    input  logic                 release_en,
    input  logic [tag_bits-1:0]  read_tag,
    output logic [wid_bits-1:0]  read_wid,
    output logic [nr_bits-1:0]   read_rd,
    output logic [num_lanes-1:0] read_tmask,
    output logic                 full
);

    logic [queue_size-1:0] valid_q;
    logic [wid_bits-1:0]   wid_mem   [queue_size];
    logic [nr_bits-1:0]    rd_mem    [queue_size];
    logic [num_lanes-1:0]  tmask_mem [queue_size];

    // lowest free entry wins
    always_comb begin
        write_tag = '0;
        for (int i = queue_size - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                write_tag = tag_bits'(i);
            end
        end
    end

    assign full = &valid_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
        end else begin
            if (acquire_en) begin
                valid_q[write_tag] <= 1'b1;
            end
            if (release_en) begin
                valid_q[read_tag] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (acquire_en) begin
            wid_mem[write_tag]   <= write_wid;
            rd_mem[write_tag]    <= write_rd;
            tmask_mem[write_tag] <= write_tmask;
        end
    end

    assign read_wid   = wid_mem[read_tag];
    assign read_rd    = rd_mem[read_tag];
    assign read_tmask = tmask_mem[read_tag];

    // the request side must hold off while every entry is taken
    assert property (@(posedge clk) disable iff (reset) acquire_en |-> !full);

    // a response can only come back for a tag that was handed out
    assert property (@(posedge clk) disable iff (reset) release_en |-> valid_q[read_tag]);

endmodule

/* src/fpu_pkg.sv */
// fpu package: widths, operation codes, flag layout and the single-precision word view
package fpu_pkg;

    localparam int num_lanes  = 2;
    localparam int num_warps  = 4;
    localparam int wid_bits   = 2;
    localparam int nr_bits    = 5;
    localparam int xlen       = 32;
    localparam int queue_size = 4;
    localparam int tag_bits   = 2;
    localparam int op_bits    = 4;

    // misc operation codes
    localparam logic [op_bits-1:0] op_sgnj   = 4'd0;
    localparam logic [op_bits-1:0] op_sgnjn  = 4'd1;
    localparam logic [op_bits-1:0] op_sgnjx  = 4'd2;
    localparam logic [op_bits-1:0] op_min    = 4'd3;
    localparam logic [op_bits-1:0] op_max    = 4'd4;
    localparam logic [op_bits-1:0] op_feq    = 4'd5;
    localparam logic [op_bits-1:0] op_flt    = 4'd6;
    localparam logic [op_bits-1:0] op_fle    = 4'd7;
    localparam logic [op_bits-1:0] op_fclass = 4'd8;

    // bit positions of the risc-v fclass mask
    localparam int cls_neg_inf  = 0;
    localparam int cls_neg_norm = 1;
    localparam int cls_neg_sub  = 2;
    localparam int cls_neg_zero = 3;
    localparam int cls_pos_zero = 4;
    localparam int cls_pos_sub  = 5;
    localparam int cls_pos_norm = 6;
    localparam int cls_pos_inf  = 7;
    localparam int cls_snan     = 8;
    localparam int cls_qnan     = 9;

    localparam logic [xlen-1:0] canonical_nan = 32'h7fc00000;

    typedef struct packed {
        logic nv;
        logic dz;
        logic of;
        logic uf;
        logic nx;
    } fflags_t;

    // one word, seen as raw bits or as ieee fields
    typedef union packed {
        logic [xlen-1:0] bits;
        struct packed {
            logic        sign;
            logic [7:0]  exp;
            logic [22:0] frac;
        } f;
    } fp32_t;

endpackage
